// File: source/fetchPkg.sv
// Fetch and branch prediction types
package fetchPkg;

	// Address and bundle geometry
	localparam int pcWidth = 32;
	localparam int slotCount = 4;
	localparam int slotBytes = 8;
	// Sequential increment of the PC
	localparam int bundleBytes = 32;

	typedef logic [pcWidth-1:0] pcAddr;

	// Control instruction kinds, encoding shared with the later pipeline
	typedef enum logic [1:0]
	{
		brReturn = 2'b00,
		brCall = 2'b01,
		brJump = 2'b10,
		brConditional = 2'b11
	} branchType;

	// Redirect request from recovery, exception, execute or decode
	typedef struct packed
	{
		logic valid;
		pcAddr target;
	} pcRedirect;

	// Resolved branch, sent in program order
	typedef struct packed
	{
		logic valid;
		pcAddr pc;
		pcAddr target;
		branchType kind;
		logic taken;
	} branchUpdate;

	// Per slot prediction, target already holds the RAS top for returns
	typedef struct packed
	{
		logic btbHit;
		branchType kind;
		logic taken;
		pcAddr target;
	} slotPrediction;

	typedef slotPrediction [slotCount-1:0] bundlePrediction;

endpackage

// File: source/icachePkg.sv
// Instruction cache line types
package icachePkg;

	// One instruction slot
	typedef logic [63:0] instrWord;

	// Whole bundle as held by one cache line, slot 0 in the low word
	typedef instrWord [fetchPkg::slotCount-1:0] fetchLine;

	// Line fill from lower memory, single cycle strobe on valid
	typedef struct packed
	{
		logic valid;
		fetchPkg::pcAddr addr;
		fetchLine data;
	} lineFill;

endpackage

// File: source/branchTargetBuffer.sv
// Banked branch target buffer
module branchTargetBuffer
#(
	parameter int btbSets = 16
)
(
	input logic clk,
	input logic reset,
	input fetchPkg::pcAddr pc_i,
	input fetchPkg::branchUpdate update_i,
	input logic updateEn_i,
	output logic [fetchPkg::slotCount-1:0] hit_o,
	output fetchPkg::branchType [fetchPkg::slotCount-1:0] kind_o,
	output fetchPkg::pcAddr [fetchPkg::slotCount-1:0] target_o
);

	// Address split: byte in slot, slot in bundle, set index, tag
	localparam int slotLow = $clog2(fetchPkg::slotBytes);
	localparam int slotBits = $clog2(fetchPkg::slotCount);
	localparam int offsetBits = $clog2(fetchPkg::bundleBytes);
	localparam int indexBits = $clog2(btbSets);
	localparam int tagBits = fetchPkg::pcWidth - offsetBits - indexBits;

	typedef struct packed
	{
		logic [tagBits-1:0] tag;
		fetchPkg::branchType kind;
		fetchPkg::pcAddr target;
	} btbEntry;

	// One bank per slot position
	btbEntry entryTable [fetchPkg::slotCount][btbSets];
	logic validTable [fetchPkg::slotCount][btbSets];

	logic [indexBits-1:0] readIndex;
	logic [tagBits-1:0] readTag;
	logic [slotBits-1:0] writeBank;
	logic [indexBits-1:0] writeIndex;
	logic [tagBits-1:0] writeTag;

	assign readIndex = pc_i[offsetBits +: indexBits];
	assign readTag = pc_i[fetchPkg::pcWidth-1 -: tagBits];
	// Update picks its bank from the slot bits of the branch PC
	assign writeBank = update_i.pc[slotLow +: slotBits];
	assign writeIndex = update_i.pc[offsetBits +: indexBits];
	assign writeTag = update_i.pc[fetchPkg::pcWidth-1 -: tagBits];

	// All banks read the same set in parallel
	always_comb
	begin
		for (int s = 0; s < fetchPkg::slotCount; s++)
		begin
			hit_o[s] = validTable[s][readIndex] && (entryTable[s][readIndex].tag == readTag);
			kind_o[s] = entryTable[s][readIndex].kind;
			target_o[s] = entryTable[s][readIndex].target;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int s = 0; s < fetchPkg::slotCount; s++)
			begin
				for (int e = 0; e < btbSets; e++)
				begin
					validTable[s][e] <= 1'b0;
				end
			end
		end
		else if (updateEn_i)
		begin
			validTable[writeBank][writeIndex] <= 1'b1;
		end
	end

	// Entry payload, tag match decides the hit
	always_ff @(posedge clk)
	begin
		if (updateEn_i)
		begin
			entryTable[writeBank][writeIndex] <= '{tag: writeTag, kind: update_i.kind,
				target: update_i.target};
		end
	end

endmodule

// File: source/branchPredictor.sv
// Bimodal direction predictor
module branchPredictor
#(
	parameter int predictorSets = 64
)
(
	input logic clk,
	input logic reset,
	input fetchPkg::pcAddr pc_i,
	input fetchPkg::pcAddr updatePc_i,
	input logic updateTaken_i,
	input logic updateEn_i,
	output logic [fetchPkg::slotCount-1:0] taken_o
);

	localparam int slotLow = $clog2(fetchPkg::slotBytes);
	localparam int slotBits = $clog2(fetchPkg::slotCount);
	localparam int offsetBits = $clog2(fetchPkg::bundleBytes);
	localparam int indexBits = $clog2(predictorSets);

	// Two bit saturating counters, one bank per slot
	logic [1:0] counterTable [fetchPkg::slotCount][predictorSets];

	logic [indexBits-1:0] readIndex;
	logic [slotBits-1:0] writeBank;
	logic [indexBits-1:0] writeIndex;
	logic [1:0] oldCount;

	assign readIndex = pc_i[offsetBits +: indexBits];
	assign writeBank = updatePc_i[slotLow +: slotBits];
	assign writeIndex = updatePc_i[offsetBits +: indexBits];
	assign oldCount = counterTable[writeBank][writeIndex];

	// Upper counter bit is the direction
	always_comb
	begin
		for (int s = 0; s < fetchPkg::slotCount; s++)
		begin
			taken_o[s] = counterTable[s][readIndex][1];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// Weakly not taken
			for (int s = 0; s < fetchPkg::slotCount; s++)
			begin
				for (int e = 0; e < predictorSets; e++)
				begin
					counterTable[s][e] <= 2'b01;
				end
			end
		end
		else if (updateEn_i)
		begin
			// Step toward the outcome, hold at 00 and 11
			if (updateTaken_i && oldCount != 2'b11)
			begin
				counterTable[writeBank][writeIndex] <= oldCount + 2'd1;
			end
			else if (!updateTaken_i && oldCount != 2'b00)
			begin
				counterTable[writeBank][writeIndex] <= oldCount - 2'd1;
			end
		end
	end

endmodule

// File: source/returnAddressStack.sv
// Circular return address stack
module returnAddressStack
#(
	parameter int rasDepth = 8
)
(
	input logic clk,
	input logic reset,
	input logic push_i,
	input logic pop_i,
	input fetchPkg::pcAddr pushAddr_i,
	output fetchPkg::pcAddr top_o
);

	localparam int ptrBits = $clog2(rasDepth);

	fetchPkg::pcAddr stackTable [rasDepth];
	logic [ptrBits-1:0] topPtr;
	logic [ptrBits-1:0] abovePtr;

	// Pointer arithmetic wraps, overflow drops the oldest entry
	assign abovePtr = topPtr + 1'b1;
	assign top_o = stackTable[topPtr];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			topPtr <= '0;
			for (int e = 0; e < rasDepth; e++)
			begin
				stackTable[e] <= '0;
			end
		end
		else if (push_i)
		begin
			stackTable[abovePtr] <= pushAddr_i;
			topPtr <= abovePtr;
		end
		else if (pop_i)
		begin
			// Underflow wraps to the other end
			topPtr <= topPtr - 1'b1;
		end
	end

endmodule

// File: source/instructionCache.sv
// Direct mapped instruction cache
module instructionCache
#(
	parameter int cacheLines = 16
)
(
	input logic clk,
	input logic reset,
	input fetchPkg::pcAddr pc_i,
	input icachePkg::lineFill fill_i,
	output icachePkg::fetchLine line_o,
	output logic hit_o
);

	// One line holds exactly one bundle
	localparam int offsetBits = $clog2(fetchPkg::bundleBytes);
	localparam int indexBits = $clog2(cacheLines);
	localparam int tagBits = fetchPkg::pcWidth - offsetBits - indexBits;

	icachePkg::fetchLine dataTable [cacheLines];
	logic [tagBits-1:0] tagTable [cacheLines];
	logic validTable [cacheLines];

	logic [indexBits-1:0] readIndex;
	logic [tagBits-1:0] readTag;
	logic [indexBits-1:0] fillIndex;
	logic [tagBits-1:0] fillTag;

	assign readIndex = pc_i[offsetBits +: indexBits];
	assign readTag = pc_i[fetchPkg::pcWidth-1 -: tagBits];
	assign fillIndex = fill_i.addr[offsetBits +: indexBits];
	assign fillTag = fill_i.addr[fetchPkg::pcWidth-1 -: tagBits];

	// Combinational read, the fill becomes visible after its edge
	assign line_o = dataTable[readIndex];
	assign hit_o = validTable[readIndex] && (tagTable[readIndex] == readTag);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int e = 0; e < cacheLines; e++)
			begin
				validTable[e] <= 1'b0;
			end
		end
		else if (fill_i.valid)
		begin
			validTable[fillIndex] <= 1'b1;
		end
	end

	// Line data and tag
	always_ff @(posedge clk)
	begin
		if (fill_i.valid)
		begin
			dataTable[fillIndex] <= fill_i.data;
			tagTable[fillIndex] <= fillTag;
		end
	end

endmodule

// File: source/fetchStage1.sv
// First fetch stage
module fetchStage1
#(
	parameter int btbSets = 16,
	parameter int predictorSets = 64,
	parameter int rasDepth = 8,
	parameter int cacheLines = 16
)
(
	input logic clk,
	input logic reset,
	input fetchPkg::pcRedirect recover_i,
	input fetchPkg::pcRedirect exception_i,
	input fetchPkg::pcRedirect redirectEx_i,
	input fetchPkg::pcRedirect redirectId_i,
	input logic stall_i,
	input fetchPkg::branchUpdate update_i,
	input icachePkg::lineFill fill_i,
	output fetchPkg::pcAddr pc_o,
	output icachePkg::fetchLine bundle_o,
	output logic bundleValid_o,
	output fetchPkg::bundlePrediction predict_o,
	output logic miss_o,
	output fetchPkg::pcAddr missAddr_o
);

	localparam int offsetBits = $clog2(fetchPkg::bundleBytes);

	fetchPkg::pcAddr pcReg;
	fetchPkg::pcAddr nextPc;

	// Table write enables
	logic btbUpdateEn;
	logic bpUpdateEn;

	// Per slot lookups
	logic [fetchPkg::slotCount-1:0] btbHit;
	fetchPkg::branchType [fetchPkg::slotCount-1:0] btbKind;
	fetchPkg::pcAddr [fetchPkg::slotCount-1:0] btbTarget;
	logic [fetchPkg::slotCount-1:0] bpTaken;
	logic [fetchPkg::slotCount-1:0] slotTaken;
	fetchPkg::pcAddr rasTop;
	logic cacheHit;

	// Outcome of the first taken slot
	logic predTaken;
	fetchPkg::pcAddr predTarget;
	logic predPush;
	logic predPop;
	fetchPkg::pcAddr pushAddr;
	logic seqAdvance;

	// Conditional entries only sit in the BTB once taken
	assign btbUpdateEn = update_i.valid &&
		(update_i.kind != fetchPkg::brConditional || update_i.taken);
	assign bpUpdateEn = update_i.valid && update_i.kind == fetchPkg::brConditional;

	branchTargetBuffer #(.btbSets(btbSets)) btb
	(
		.clk(clk),
		.reset(reset),
		.pc_i(pcReg),
		.update_i(update_i),
		.updateEn_i(btbUpdateEn),
		.hit_o(btbHit),
		.kind_o(btbKind),
		.target_o(btbTarget)
	);

	branchPredictor #(.predictorSets(predictorSets)) bp
	(
		.clk(clk),
		.reset(reset),
		.pc_i(pcReg),
		.updatePc_i(update_i.pc),
		.updateTaken_i(update_i.taken),
		.updateEn_i(bpUpdateEn),
		.taken_o(bpTaken)
	);

	// Stack moves only on a plain sequential or predicted advance
	returnAddressStack #(.rasDepth(rasDepth)) ras
	(
		.clk(clk),
		.reset(reset),
		.push_i(seqAdvance && predPush),
		.pop_i(seqAdvance && predPop),
		.pushAddr_i(pushAddr),
		.top_o(rasTop)
	);

	instructionCache #(.cacheLines(cacheLines)) icache
	(
		.clk(clk),
		.reset(reset),
		.pc_i(pcReg),
		.fill_i(fill_i),
		.line_o(bundle_o),
		.hit_o(cacheHit)
	);

	// Taken when the BTB hits and the entry is unconditional or the counter says taken
	always_comb
	begin
		for (int s = 0; s < fetchPkg::slotCount; s++)
		begin
			slotTaken[s] = btbHit[s] &&
				(btbKind[s] != fetchPkg::brConditional || bpTaken[s]);
			predict_o[s].btbHit = btbHit[s];
			predict_o[s].kind = btbKind[s];
			predict_o[s].taken = slotTaken[s];
			// Returns take their target from the stack
			predict_o[s].target = (btbKind[s] == fetchPkg::brReturn) ? rasTop : btbTarget[s];
		end
	end

	// First taken slot, scanned from the top so the lowest index wins
	always_comb
	begin
		predTaken = 1'b0;
		predTarget = '0;
		predPush = 1'b0;
		predPop = 1'b0;
		pushAddr = '0;
		for (int s = fetchPkg::slotCount - 1; s >= 0; s--)
		begin
			if (slotTaken[s])
			begin
				predTaken = 1'b1;
				predTarget = (btbKind[s] == fetchPkg::brReturn) ? rasTop : btbTarget[s];
				predPop = (btbKind[s] == fetchPkg::brReturn);
				predPush = (btbKind[s] == fetchPkg::brCall);
				// Return address is the slot after the call
				pushAddr = pcReg + fetchPkg::pcAddr'(fetchPkg::slotBytes * (s + 1));
			end
		end
	end

	// Rule 4 applies, no decode redirect
	assign seqAdvance = !recover_i.valid && !exception_i.valid && !redirectEx_i.valid &&
		!stall_i && cacheHit && !redirectId_i.valid;

	// Next PC priority, execute redirect also acts under stall
	always_comb
	begin
		nextPc = pcReg;
		if (recover_i.valid)
		begin
			nextPc = recover_i.target;
		end
		else if (exception_i.valid)
		begin
			nextPc = exception_i.target;
		end
		else if (redirectEx_i.valid)
		begin
			nextPc = redirectEx_i.target;
		end
		else if (!stall_i && cacheHit)
		begin
			if (redirectId_i.valid)
			begin
				nextPc = redirectId_i.target;
			end
			else if (predTaken)
			begin
				nextPc = predTarget;
			end
			else
			begin
				nextPc = pcReg + fetchPkg::pcAddr'(fetchPkg::bundleBytes);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pcReg <= '0;
		end
		else
		begin
			pcReg <= nextPc;
		end
	end

	assign pc_o = pcReg;
	assign bundleValid_o = cacheHit;
	assign miss_o = !cacheHit;
	// Miss address aligned to the bundle
	assign missAddr_o = {pcReg[fetchPkg::pcWidth-1:offsetBits], {offsetBits{1'b0}}};

endmodule

// File: test/fetchStage1Tb.sv
// Fetch stage testbench
module fetchStage1Tb;

	// Mirrors of the DUT parameter defaults
	localparam int btbSets = 16;
	localparam int predictorSets = 64;
	localparam int rasDepth = 8;
	localparam int cacheLines = 16;
	localparam int offsetBits = $clog2(fetchPkg::bundleBytes);
	localparam int randomCycles = 4000;
	localparam int missTimeout = 20;

	logic clk = 1'b0;
	logic reset;
	fetchPkg::pcRedirect recover_i;
	fetchPkg::pcRedirect exception_i;
	fetchPkg::pcRedirect redirectEx_i;
	fetchPkg::pcRedirect redirectId_i;
	logic stall_i;
	fetchPkg::branchUpdate update_i;
	icachePkg::lineFill fill_i;
	fetchPkg::pcAddr pc_o;
	icachePkg::fetchLine bundle_o;
	logic bundleValid_o;
	fetchPkg::bundlePrediction predict_o;
	logic miss_o;
	fetchPkg::pcAddr missAddr_o;

	integer seed;
	int fillDelay;

	// Reference copies of tables, stack, cache and PC
	fetchPkg::pcAddr mPc;
	logic mBtbValid [fetchPkg::slotCount][btbSets];
	fetchPkg::pcAddr mBtbPc [fetchPkg::slotCount][btbSets];
	fetchPkg::pcAddr mBtbTarget [fetchPkg::slotCount][btbSets];
	fetchPkg::branchType mBtbKind [fetchPkg::slotCount][btbSets];
	logic [1:0] mCounter [fetchPkg::slotCount][predictorSets];
	fetchPkg::pcAddr mRas [rasDepth];
	int mRasPtr;
	logic mCacheValid [cacheLines];
	fetchPkg::pcAddr mCacheAddr [cacheLines];
	icachePkg::fetchLine mCacheData [cacheLines];

	fetchStage1 uut
	(
		.clk(clk),
		.reset(reset),
		.recover_i(recover_i),
		.exception_i(exception_i),
		.redirectEx_i(redirectEx_i),
		.redirectId_i(redirectId_i),
		.stall_i(stall_i),
		.update_i(update_i),
		.fill_i(fill_i),
		.pc_o(pc_o),
		.bundle_o(bundle_o),
		.bundleValid_o(bundleValid_o),
		.predict_o(predict_o),
		.miss_o(miss_o),
		.missAddr_o(missAddr_o)
	);

	always #4 clk = ~clk;

	function automatic int drawBelow(int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	function automatic logic rollPercent(int pct);
		return drawBelow(100) < pct;
	endfunction

	// Six neighbouring bundles plus two that alias them in the cache and BTB
	function automatic fetchPkg::pcAddr poolAddr(int k);
		return 32'h1000 + (k % 6) * fetchPkg::bundleBytes + ((k >= 6) ? 32'h200 : 32'h0);
	endfunction

	function automatic icachePkg::fetchLine randomLine();
		icachePkg::fetchLine line;
		for (int w = 0; w < fetchPkg::slotCount; w++)
		begin
			line[w] = {$random(seed), $random(seed)};
		end
		return line;
	endfunction

	function automatic fetchPkg::pcAddr alignBundle(fetchPkg::pcAddr a);
		return (a >> offsetBits) << offsetBits;
	endfunction

	function automatic logic cacheHits(fetchPkg::pcAddr a);
		int idx;
		idx = (a >> offsetBits) % cacheLines;
		return mCacheValid[idx] &&
			((mCacheAddr[idx] >> offsetBits) / cacheLines == (a >> offsetBits) / cacheLines);
	endfunction

	// Per slot lookup where returns take the stack top
	function automatic fetchPkg::bundlePrediction expectPrediction(fetchPkg::pcAddr a);
		fetchPkg::bundlePrediction p;
		int bi;
		int ci;
		bi = (a >> offsetBits) % btbSets;
		ci = (a >> offsetBits) % predictorSets;
		for (int s = 0; s < fetchPkg::slotCount; s++)
		begin
			p[s].btbHit = mBtbValid[s][bi] &&
				((mBtbPc[s][bi] >> offsetBits) / btbSets == (a >> offsetBits) / btbSets);
			p[s].kind = mBtbKind[s][bi];
			p[s].taken = p[s].btbHit &&
				(p[s].kind != fetchPkg::brConditional || mCounter[s][ci][1]);
			p[s].target = (p[s].kind == fetchPkg::brReturn) ? mRas[mRasPtr] : mBtbTarget[s][bi];
		end
		return p;
	endfunction

	task automatic stopWithFailure();
		$display("Something failed");
		$fatal(1, "run aborted");
	endtask

	task automatic checkPc(string what, fetchPkg::pcAddr got, fetchPkg::pcAddr exp);
		if (got !== exp)
		begin
			$display("error %0t: %s is %h, expected %h", $time, what, got, exp);
			stopWithFailure();
		end
	endtask

	task automatic checkLine(icachePkg::fetchLine got, icachePkg::fetchLine exp);
		if (got !== exp)
		begin
			$display("error %0t: bundle_o is %h, expected %h", $time, got, exp);
			stopWithFailure();
		end
	endtask

	task automatic checkMiss(string what, logic got, logic exp);
		if (got !== exp)
		begin
			$display("error %0t: %s is %b, expected %b", $time, what, got, exp);
			stopWithFailure();
		end
	endtask

	// Kind and target only matter on a BTB hit
	task automatic checkPrediction(fetchPkg::bundlePrediction got,
		fetchPkg::bundlePrediction exp);
		for (int s = 0; s < fetchPkg::slotCount; s++)
		begin
			if (got[s].btbHit !== exp[s].btbHit || got[s].taken !== exp[s].taken ||
				(exp[s].btbHit && (got[s].kind !== exp[s].kind ||
				got[s].target !== exp[s].target)))
			begin
				$display("error %0t: slot %0d hit %b taken %b kind %0d target %h", $time, s,
					got[s].btbHit, got[s].taken, got[s].kind, got[s].target);
				$display("  expected hit %b taken %b kind %0d target %h", exp[s].btbHit,
					exp[s].taken, exp[s].kind, exp[s].target);
				stopWithFailure();
			end
		end
	endtask

	task automatic checkOutputs();
		logic hit;
		hit = cacheHits(mPc);
		checkPc("pc_o", pc_o, mPc);
		checkMiss("miss_o", miss_o, !hit);
		checkMiss("bundleValid_o", bundleValid_o, hit);
		if (hit)
		begin
			checkLine(bundle_o, mCacheData[(mPc >> offsetBits) % cacheLines]);
		end
		else
		begin
			checkPc("missAddr_o", missAddr_o, alignBundle(mPc));
		end
		checkPrediction(predict_o, expectPrediction(mPc));
	endtask

	task automatic resetModel();
		mPc = '0;
		mRasPtr = 0;
		fillDelay = 0;
		for (int e = 0; e < rasDepth; e++)
		begin
			mRas[e] = '0;
		end
		for (int s = 0; s < fetchPkg::slotCount; s++)
		begin
			for (int e = 0; e < btbSets; e++)
			begin
				mBtbValid[s][e] = 1'b0;
				mBtbPc[s][e] = '0;
				mBtbTarget[s][e] = '0;
				mBtbKind[s][e] = fetchPkg::brJump;
			end
			// Weakly not taken
			for (int e = 0; e < predictorSets; e++)
			begin
				mCounter[s][e] = 2'b01;
			end
		end
		for (int e = 0; e < cacheLines; e++)
		begin
			mCacheValid[e] = 1'b0;
			mCacheAddr[e] = '0;
			mCacheData[e] = '0;
		end
	endtask

	// Next PC and table state after the coming edge
	// Reads see the state before that edge
	task automatic modelStep();
		fetchPkg::bundlePrediction p;
		fetchPkg::pcAddr nextPc;
		fetchPkg::pcAddr pushAddr;
		logic push;
		logic pop;
		int first;
		int bank;
		int idx;
		p = expectPrediction(mPc);
		first = -1;
		push = 1'b0;
		pop = 1'b0;
		pushAddr = '0;
		nextPc = mPc;
		for (int s = 0; s < fetchPkg::slotCount; s++)
		begin
			if (first < 0 && p[s].taken)
			begin
				first = s;
			end
		end
		if (recover_i.valid)
		begin
			nextPc = recover_i.target;
		end
		else if (exception_i.valid)
		begin
			nextPc = exception_i.target;
		end
		else if (redirectEx_i.valid)
		begin
			nextPc = redirectEx_i.target;
		end
		else if (!stall_i && cacheHits(mPc))
		begin
			if (redirectId_i.valid)
			begin
				nextPc = redirectId_i.target;
			end
			else if (first >= 0)
			begin
				nextPc = p[first].target;
				pop = p[first].kind == fetchPkg::brReturn;
				push = p[first].kind == fetchPkg::brCall;
				pushAddr = mPc + fetchPkg::slotBytes * (first + 1);
			end
			else
			begin
				nextPc = mPc + fetchPkg::bundleBytes;
			end
		end
		// Circular stack that wraps both ways
		if (push)
		begin
			mRasPtr = (mRasPtr + 1) % rasDepth;
			mRas[mRasPtr] = pushAddr;
		end
		else if (pop)
		begin
			mRasPtr = (mRasPtr + rasDepth - 1) % rasDepth;
		end
		if (update_i.valid)
		begin
			bank = (update_i.pc / fetchPkg::slotBytes) % fetchPkg::slotCount;
			idx = (update_i.pc >> offsetBits) % btbSets;
			if (update_i.kind != fetchPkg::brConditional || update_i.taken)
			begin
				mBtbValid[bank][idx] = 1'b1;
				mBtbPc[bank][idx] = update_i.pc;
				mBtbKind[bank][idx] = update_i.kind;
				mBtbTarget[bank][idx] = update_i.target;
			end
			idx = (update_i.pc >> offsetBits) % predictorSets;
			if (update_i.kind == fetchPkg::brConditional)
			begin
				if (update_i.taken && mCounter[bank][idx] != 2'b11)
				begin
					mCounter[bank][idx] = mCounter[bank][idx] + 2'd1;
				end
				else if (!update_i.taken && mCounter[bank][idx] != 2'b00)
				begin
					mCounter[bank][idx] = mCounter[bank][idx] - 2'd1;
				end
			end
		end
		if (fill_i.valid)
		begin
			idx = (fill_i.addr >> offsetBits) % cacheLines;
			mCacheValid[idx] = 1'b1;
			mCacheAddr[idx] = fill_i.addr;
			mCacheData[idx] = fill_i.data;
		end
		mPc = nextPc;
	endtask

	task automatic clearInputs();
		recover_i = '0;
		exception_i = '0;
		redirectEx_i = '0;
		redirectId_i = '0;
		stall_i = 1'b0;
		update_i = '0;
		fill_i = '0;
	endtask

	// Inputs change on the falling edge and outputs are checked one cycle later
	task automatic advanceCycle();
		modelStep();
		@(negedge clk);
		checkOutputs();
	endtask

	task automatic waitMissClear();
		int n;
		n = 0;
		while (miss_o === 1'b1 && n < missTimeout)
		begin
			clearInputs();
			advanceCycle();
			n++;
		end
		if (miss_o !== 1'b0)
		begin
			$display("the cache miss at %h never cleared after its line fill", missAddr_o);
			stopWithFailure();
		end
	endtask

	task automatic randomInputs();
		fetchPkg::branchType kind;
		clearInputs();
		if (rollPercent(3))
		begin
			recover_i = '{valid: 1'b1, target: poolAddr(drawBelow(8))};
		end
		if (rollPercent(3))
		begin
			exception_i = '{valid: 1'b1, target: poolAddr(drawBelow(8))};
		end
		if (rollPercent(5))
		begin
			redirectEx_i = '{valid: 1'b1, target: poolAddr(drawBelow(8))};
		end
		if (rollPercent(8))
		begin
			redirectId_i = '{valid: 1'b1, target: poolAddr(drawBelow(8))};
		end
		stall_i = rollPercent(15);
		// Trained slots land in the pool so fetches revisit them
		if (rollPercent(40))
		begin
			kind = fetchPkg::branchType'(drawBelow(4));
			update_i.valid = 1'b1;
			update_i.pc = poolAddr(drawBelow(8)) + fetchPkg::slotBytes * drawBelow(4);
			update_i.target = poolAddr(drawBelow(8));
			update_i.kind = kind;
			update_i.taken = (kind == fetchPkg::brConditional) ? rollPercent(70) : 1'b1;
		end
		// Lower memory answers a miss after a short random delay
		if (!cacheHits(mPc))
		begin
			if (fillDelay == 0)
			begin
				fill_i = '{valid: 1'b1, addr: alignBundle(mPc), data: randomLine()};
				fillDelay = drawBelow(4);
			end
			else
			begin
				fillDelay--;
			end
		end
	endtask

	initial
	begin
		seed = 44825;
		reset = 1'b1;
		clearInputs();
		resetModel();
		repeat (10) @(negedge clk);
		reset = 1'b0;
		// PC zero and missing straight out of reset
		checkOutputs();
		fill_i = '{valid: 1'b1, addr: '0, data: randomLine()};
		advanceCycle();
		waitMissClear();
		// Filling one line ahead keeps the PC stepping by a bundle
		for (int k = 1; k <= 4; k++)
		begin
			clearInputs();
			fill_i = '{valid: 1'b1, addr: k * fetchPkg::bundleBytes, data: randomLine()};
			advanceCycle();
		end
		// Miss holds the PC until its fill
		clearInputs();
		repeat (4) advanceCycle();
		fill_i = '{valid: 1'b1, addr: alignBundle(mPc), data: randomLine()};
		advanceCycle();
		waitMissClear();
		// Recover beats exception
		clearInputs();
		recover_i = '{valid: 1'b1, target: poolAddr(1)};
		exception_i = '{valid: 1'b1, target: poolAddr(2)};
		advanceCycle();
		// Execute redirect under stall
		clearInputs();
		stall_i = 1'b1;
		redirectEx_i = '{valid: 1'b1, target: poolAddr(3)};
		// Target line lands at the same edge so the next bundle hits
		fill_i = '{valid: 1'b1, addr: poolAddr(3), data: randomLine()};
		advanceCycle();
		// Decode redirect ignored under stall
		clearInputs();
		stall_i = 1'b1;
		redirectId_i = '{valid: 1'b1, target: poolAddr(4)};
		advanceCycle();
		for (int c = 0; c < randomCycles; c++)
		begin
			randomInputs();
			advanceCycle();
		end
		$display("Everything OK");
		$finish;
	end

endmodule

// File: sources.f
source/fetchPkg.sv
source/icachePkg.sv
source/branchTargetBuffer.sv
source/branchPredictor.sv
source/returnAddressStack.sv
source/instructionCache.sv
source/fetchStage1.sv
test/fetchStage1Tb.sv
